// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := icFetchTb
FLIST      := list.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -j 0
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

obj_dir/V$(TOP): $(shell cat $(FLIST))
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== common/icachePkg.sv ====
// geometry and data types of the L1 instruction cache

package icachePkg;

	localparam int IC_IX_BITS = 6;	// index bits per bank
	localparam int IC_LINES = 1 << IC_IX_BITS;	// lines per bank
	localparam int IC_LINE_BITS = 128;
	localparam int IC_LA_BITS = 28;	// line address width
	localparam int IC_WIN_BITS = 96;	// window handed to the PC unit

	// PC split into line address and byte offset
	// offset bit 3 selects the half-line, bits 2 to 1 the halfword
	typedef struct packed
	{
		logic [IC_LA_BITS-1:0] lineAddr;
		logic [3:0] offset;
	} fetchFieldsS;

	typedef union packed
	{
		logic [31:0] raw;
		fetchFieldsS fields;
	} fetchAddrU;

	// tag entry as stored in a bank
	typedef struct packed
	{
		logic [3:0] flag;	// low bits hold ~lineAddr[1:0]
		logic [IC_LA_BITS-1:0] lineAddr;
	} tagEntryS;

	// bank write port
	typedef struct packed
	{
		logic we;
		logic [IC_IX_BITS-1:0] ix;
		tagEntryS tag;
		logic [IC_LINE_BITS-1:0] data;
	} bankFillS;

	// how far the PC unit advances
	typedef enum logic [2:0]
	{
		step16 = 3'd1,
		step32 = 3'd2,
		step48 = 3'd3,
		stepWide2 = 3'd4,	// two 32-bit ops
		stepWide3 = 3'd6	// three ops
	} stepE;

	// result towards the PC unit
	typedef struct packed
	{
		logic [IC_WIN_BITS-1:0] window;
		stepE step;
		memBusPkg::memOkE ok;
	} fetchOutS;

endpackage

// ==== common/memBusPkg.sv ====
// tile memory port shared by the fetch cache and the memory model

package memBusPkg;

	localparam int MEM_ADDR_BITS = 32;	// byte address on the port
	localparam int MEM_TILE_BITS = 128;	// one 16-byte tile per transfer

	// operation codes driven by the requester
	typedef enum logic [4:0]
	{
		opmReady  = 5'h00,	// port idle
		opmRdTile = 5'h11	// read one tile
	} memOpmE;

	// status codes returned by the memory side
	typedef enum logic [1:0]
	{
		okReady = 2'b00,	// idle, ready for a new operation
		okOk    = 2'b01,	// data valid this cycle
		okHold  = 2'b10,	// still working
		okFault = 2'b11		// access failed
	} memOkE;

	// request from the cache
	typedef struct packed
	{
		logic [MEM_ADDR_BITS-1:0] addr;	// tile aligned
		memOpmE opm;
	} memReqS;

endpackage

// ==== dv/icFetchTb.sv ====
`timescale 1ns/1ps

module icFetchTb;
	import icachePkg::*;
	import memBusPkg::*;

	localparam int WALK_FETCHES = 2048;	// 4 KB in halfword steps
	localparam int HIT_FETCHES = 1011;	// 0x1810 to 0x1ff4
	localparam int WIDE_FETCHES = 512;
	localparam int NUM_FETCHES = 1 + WALK_FETCHES + HIT_FETCHES + 8 + WIDE_FETCHES + 3;

	logic clock;
	logic arstN;
	logic [31:0] pc;
	logic pcHold;
	logic wideExec;
	logic [MEM_TILE_BITS-1:0] memData;
	memOkE memOk;
	fetchOutS fetch;
	memReqS memReq;

	int errors;
	int checks;
	int tests;
	int cycleCnt;
	int issueCycle;
	int lastLatency;
	int tileReads;
	int faultSeen;
	int wide4Seen;
	int wide6Seen;
	logic pending;
	logic [31:0] curPc;
	logic curWide;
	logic injectFault;

	// memory model state
	logic busy;
	int waitLeft;
	logic [31:0] reqAddr;

	icFetchTop i_icFetchTop
	(
		.clock(clock),
		.arstN(arstN),
		.pc(pc),
		.pcHold(pcHold),
		.wideExec(wideExec),
		.memData(memData),
		.memOk(memOk),
		.fetch(fetch),
		.memReq(memReq)
	);

	always #2 clock = ~clock;

	always @(posedge clock)
		cycleCnt <= cycleCnt + 1;

	// halfword stored at a byte address, biased towards long ops
	function automatic logic [15:0] hwAt(input logic [31:0] a);
		logic [31:0] x;
		logic [15:0] h;
		x = (a >> 1) * 32'h9e37_79b1;
		h = x[31:16] ^ x[15:0];
		if (x[3:2] != 2'b00)
			h[15:13] = 3'b111;
		return h;
	endfunction

	function automatic logic [127:0] tileData(input logic [31:0] a);
		logic [127:0] d;
		for (int k = 0; k < 8; k++)
			d[16*k +: 16] = hwAt(a + 32'(2 * k));
		return d;
	endfunction

	function automatic logic bundleStart(input logic [15:0] w);
		if (w[15:13] != 3'b111 || !w[12])
			return 1'b0;
		return (w[11:10] == 2'b01) || (w[11:10] == 2'b10 && w[8]);
	endfunction

	// expected {step, window} for a PC
	function automatic logic [98:0] refFetch(input logic [31:0] p, input logic wide);
		logic [95:0] win;
		logic [2:0] step;
		logic [31:0] base;
		base = {p[31:1], 1'b0};
		for (int k = 0; k < 6; k++)
			win[16*k +: 16] = hwAt(base + 32'(2 * k));
		if (win[15:13] != 3'b111)
			step = 3'd1;
		else if (win[11:10] == 2'b11)
			step = 3'd3;
		else
			step = 3'd2;
		if (wide && bundleStart(win[15:0]))
			step = bundleStart(win[47:32]) ? 3'd6 : 3'd4;
		return {step, win};
	endfunction

	task automatic checkVal(input string what, input logic [127:0] got, input logic [127:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %0t ns %s: got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic reportTest(input string name, input int errStart);
		tests++;
		$display("test %s finished with %0d errors", name, errors - errStart);
	endtask

	// memory side of the tile port
	always
	begin
		@(posedge clock);
		#0.5;
		if (!arstN)
		begin
			memOk = okReady;
			busy = 1'b0;
		end
		else if (busy)
		begin
			waitLeft--;
			if (waitLeft == 0)
			begin
				memData = tileData(reqAddr);
				memOk = injectFault ? okFault : okOk;
				injectFault = 1'b0;
				busy = 1'b0;
			end
		end
		else
		begin
			memOk = okReady;
			if (memReq.opm == opmRdTile)
			begin
				// only the current line or the next one may be requested
				checkVal("tile line address",
					128'((memReq.addr[31:4] == curPc[31:4]) ||
					(memReq.addr[31:4] == curPc[31:4] + 28'd1)), 128'(1));
				checkVal("tile alignment", 128'(memReq.addr[3:0]), 128'(0));
				busy = 1'b1;
				reqAddr = memReq.addr;
				waitLeft = 1 + int'($urandom % 5);	// 1 to 5 cycles
				tileReads++;
				memOk = okHold;
			end
		end
	end

	// compare process, outputs are settled by the falling edge
	always @(negedge clock)
	begin
		logic [98:0] expVal;
		// the new PC reaches the cache stage at the first edge after issue
		if (pending && cycleCnt != issueCycle)
		begin
			if (fetch.ok == okFault)
				faultSeen++;
			else if (fetch.ok == okOk)
			begin
				expVal = refFetch(curPc, curWide);
				checkVal($sformatf("window at %h", curPc), 128'(fetch.window), 128'(expVal[95:0]));
				checkVal($sformatf("step at %h", curPc), 128'(3'(fetch.step)),
					128'(expVal[98:96]));
				if (fetch.step == stepWide2)
					wide4Seen++;
				if (fetch.step == stepWide3)
					wide6Seen++;
				lastLatency = cycleCnt - issueCycle;
				pending = 1'b0;
			end
		end
	end

	// called just after a rising edge
	task automatic fetchOne(input logic [31:0] p, input logic wide);
		pc = p;
		wideExec = wide;
		pcHold = 1'b0;
		curPc = p;
		curWide = wide;
		issueCycle = cycleCnt;
		pending = 1'b1;
		do
		begin
			@(posedge clock);
			#0.5;
			if (pending)
				pcHold = 1'b1;	// replay the PC while on hold
		end
		while (pending);
	endtask

	initial
	begin
		#(NUM_FETCHES * 20 * 4 + 200);
		$display("timeout: fetches did not complete in the expected time");
		$display("Test FAILED");
		$finish;
	end

	initial
	begin
		int errStart;
		int rd0;
		int f0;
		clock = 1'b0;
		arstN = 1'b0;
		pc = '0;
		pcHold = 1'b0;
		wideExec = 1'b0;
		memData = '0;
		memOk = okReady;
		errors = 0;
		checks = 0;
		tests = 0;
		cycleCnt = 0;
		issueCycle = 0;
		tileReads = 0;
		faultSeen = 0;
		wide4Seen = 0;
		wide6Seen = 0;
		pending = 1'b0;
		injectFault = 1'b0;
		busy = 1'b0;
		void'($urandom(32'h1dce_2bdd));

		// reset, port must stay idle
		errStart = errors;
		repeat (10)
		begin
			@(posedge clock);
			#0.5;
			checkVal("memReq idle in reset", 128'(memReq.opm), 128'(opmReady));
		end
		arstN = 1'b1;
		fetchOne(32'h0000_0100, 1'b0);
		checkVal("first fetch misses", 128'(lastLatency > 1), 128'(1));
		reportTest("reset", errStart);

		errStart = errors;
		for (int i = 0; i < WALK_FETCHES; i++)
			fetchOne(32'h1000 + 32'(2 * i), 1'b0);
		reportTest("walk", errStart);

		// last 2 KB of the walk is still cached
		errStart = errors;
		for (int i = 0; i < HIT_FETCHES; i++)
		begin
			rd0 = tileReads;
			fetchOne(32'h1810 + 32'(2 * i), 1'b0);
			checkVal("hit latency", 128'(lastLatency), 128'(1));
			checkVal("no tile read on hit", 128'(tileReads), 128'(rd0));
		end
		reportTest("refetch", errStart);

		errStart = errors;
		for (int i = 0; i < 8; i++)
		begin
			fetchOne((i % 2 == 0) ? 32'h4020 : 32'h4820, 1'b0);	// same index
			checkVal("alias refill", 128'(lastLatency > 1), 128'(1));
		end
		reportTest("alias", errStart);

		errStart = errors;
		for (int i = 0; i < WIDE_FETCHES; i++)
			fetchOne(32'h6000 + 32'(2 * i), 1'b1);
		checkVal("step 4 seen", 128'(wide4Seen > 0), 128'(1));
		checkVal("step 6 seen", 128'(wide6Seen > 0), 128'(1));
		reportTest("wide", errStart);

		errStart = errors;
		f0 = faultSeen;
		injectFault = 1'b1;
		fetchOne(32'h8000, 1'b0);
		checkVal("fault status", 128'(faultSeen - f0), 128'(1));
		fetchOne(32'h8000, 1'b0);
		checkVal("hit after fault", 128'(lastLatency), 128'(1));
		fetchOne(32'h8010, 1'b0);
		reportTest("fault", errStart);

		$display("tests %0d checks %0d errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// ==== hdl/icFetchTop.sv ====
`timescale 1ns/1ps

// L1 instruction fetch cache, two banks plus the miss controller

module icFetchTop
(
	input logic clock,
	input logic arstN,
	input logic [31:0] pc,
	input logic pcHold,
	input logic wideExec,
	input logic [memBusPkg::MEM_TILE_BITS-1:0] memData,
	input memBusPkg::memOkE memOk,
	output icachePkg::fetchOutS fetch,
	output memBusPkg::memReqS memReq
);
	import icachePkg::*;

	fetchAddrU pcEff;
	fetchAddrU pcReg;
	logic [IC_LA_BITS-1:0] nxtEven;
	logic [IC_LA_BITS-1:0] nxtOdd;
	logic [IC_LA_BITS-1:0] reqEven;
	logic [IC_LA_BITS-1:0] reqOdd;
	logic [IC_IX_BITS-1:0] nxtIxEven;
	logic [IC_IX_BITS-1:0] nxtIxOdd;
	logic [IC_IX_BITS-1:0] ixEven;
	logic [IC_IX_BITS-1:0] ixOdd;
	tagEntryS tagEven;
	tagEntryS tagOdd;
	logic [IC_LINE_BITS-1:0] dataEven;
	logic [IC_LINE_BITS-1:0] dataOdd;
	logic missEven;
	logic missOdd;
	bankFillS fillEven;
	bankFillS fillOdd;

	always_comb
	begin
		pcEff.raw = pcHold ? pcReg.raw : pc;	// replay while held
		// current line in its own bank, next line in the other
		if (pcEff.fields.lineAddr[0])
		begin
			nxtOdd = pcEff.fields.lineAddr;
			nxtEven = pcEff.fields.lineAddr + IC_LA_BITS'(1);
		end
		else
		begin
			nxtEven = pcEff.fields.lineAddr;
			nxtOdd = pcEff.fields.lineAddr + IC_LA_BITS'(1);
		end
		nxtIxEven = nxtEven[IC_IX_BITS:1];	// bit 0 picks the bank
		nxtIxOdd = nxtOdd[IC_IX_BITS:1];
	end

	// stage registers, aligned with the bank read data
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			pcReg <= '0;
			reqEven <= '0;
			reqOdd <= '0;
			ixEven <= '0;
			ixOdd <= '0;
		end
		else
		begin
			pcReg <= pcEff;
			reqEven <= nxtEven;
			reqOdd <= nxtOdd;
			ixEven <= nxtIxEven;
			ixOdd <= nxtIxOdd;
		end
	end

	icBank iEven
	(
		.clock(clock),
		.arstN(arstN),
		.rdIx(nxtIxEven),
		.fill(fillEven),
		.rdTag(tagEven),
		.rdData(dataEven)
	);

	icBank iOdd
	(
		.clock(clock),
		.arstN(arstN),
		.rdIx(nxtIxOdd),
		.fill(fillOdd),
		.rdTag(tagOdd),
		.rdData(dataOdd)
	);

	icFetchAlign iAlign
	(
		.pcReg(pcReg),
		.reqEven(reqEven),
		.reqOdd(reqOdd),
		.tagEven(tagEven),
		.tagOdd(tagOdd),
		.dataEven(dataEven),
		.dataOdd(dataOdd),
		.wideExec(wideExec),
		.memOk(memOk),
		.fetch(fetch),
		.missEven(missEven),
		.missOdd(missOdd)
	);

	icMissCtl iMissCtl
	(
		.clock(clock),
		.arstN(arstN),
		.missEven(missEven),
		.missOdd(missOdd),
		.reqEven(reqEven),
		.reqOdd(reqOdd),
		.ixEven(ixEven),
		.ixOdd(ixOdd),
		.memData(memData),
		.memOk(memOk),
		.memReq(memReq),
		.fillEven(fillEven),
		.fillOdd(fillOdd)
	);

endmodule

// ==== icache/icBank.sv ====
`timescale 1ns/1ps

// one bank of the fetch cache
// even lines live in one instance and odd lines in the other

module icBank
(
	input logic clock,
	input logic arstN,
	input logic [icachePkg::IC_IX_BITS-1:0] rdIx,
	input icachePkg::bankFillS fill,
	output icachePkg::tagEntryS rdTag,
	output logic [icachePkg::IC_LINE_BITS-1:0] rdData
);
	import icachePkg::*;

	tagEntryS tagMem [IC_LINES];	// small, kept as flops
	logic [IC_LINE_BITS-1:0] dataMem [IC_LINES];	// distributed RAM

	// all-zero tags fail the check flag test, so every line misses after reset
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < IC_LINES; i++)
				tagMem[i] <= '0;
			rdTag <= '0;
		end
		else
		begin
			if (fill.we)
				tagMem[fill.ix] <= fill.tag;
			rdTag <= tagMem[rdIx];	// old entry on a same-cycle write
		end
	end

	// data side
	always_ff @(posedge clock)
	begin
		if (fill.we)
			dataMem[fill.ix] <= fill.data;
		rdData <= dataMem[rdIx];
	end

endmodule

// ==== icache/icFetchAlign.sv ====
`timescale 1ns/1ps

// hit check and window alignment for the fetch cache

module icFetchAlign
(
	input icachePkg::fetchAddrU pcReg,
	input logic [icachePkg::IC_LA_BITS-1:0] reqEven,
	input logic [icachePkg::IC_LA_BITS-1:0] reqOdd,
	input icachePkg::tagEntryS tagEven,
	input icachePkg::tagEntryS tagOdd,
	input logic [icachePkg::IC_LINE_BITS-1:0] dataEven,
	input logic [icachePkg::IC_LINE_BITS-1:0] dataOdd,
	input logic wideExec,
	input memBusPkg::memOkE memOk,
	output icachePkg::fetchOutS fetch,
	output logic missEven,
	output logic missOdd
);
	import icachePkg::*;
	import memBusPkg::*;

	logic [IC_LINE_BITS+31:0] win160;	// current line plus 32 bits of the next
	logic [IC_WIN_BITS-1:0] win96;
	logic [2:0] lenA;	// first op
	logic [2:0] lenB;	// op two halfwords later

	// bit 2 marks a bundle start, bits 1 to 0 the plain step
	function automatic logic [2:0] opLen(input logic [15:0] w);
		logic [2:0] len;
		casez ({w[15:13], w[11:10], w[8]})
			6'b111_11?: len = 3'b011;
			6'b111_101: len = 3'b110;
			6'b111_100: len = 3'b010;
			6'b111_01?: len = 3'b110;
			6'b111_00?: len = 3'b010;
			default: len = 3'b001;
		endcase
		len[2] = len[2] & w[12];	// bundle start needs bit 12
		return len;
	endfunction

	always_comb
	begin
		missEven = (tagEven.lineAddr != reqEven) ||
			(tagEven.flag[1:0] != ~tagEven.lineAddr[1:0]);
		missOdd = (tagOdd.lineAddr != reqOdd) ||
			(tagOdd.flag[1:0] != ~tagOdd.lineAddr[1:0]);

		// bank order from line bit 0, start from the half-line
		case ({pcReg.fields.lineAddr[0], pcReg.fields.offset[3]})
			2'b00: win160 = {dataOdd[31:0], dataEven};
			2'b01: win160 = {dataOdd[95:0], dataEven[127:64]};
			2'b10: win160 = {dataEven[31:0], dataOdd};
			default: win160 = {dataEven[95:0], dataOdd[127:64]};
		endcase

		win96 = win160[{pcReg.fields.offset[2:1], 4'b0000} +: IC_WIN_BITS];

		lenA = opLen(win96[15:0]);
		lenB = opLen(win96[47:32]);

		fetch.window = win96;
		fetch.step = stepE'({1'b0, lenA[1:0]});
		if (wideExec && lenA[2])
			fetch.step = lenB[2] ? stepWide3 : stepWide2;

		// a fault overrides everything for this cycle
		if (memOk == okFault)
			fetch.ok = okFault;
		else if (missEven || missOdd)
			fetch.ok = okHold;
		else
			fetch.ok = okOk;
	end

endmodule

// ==== icache/icMissCtl.sv ====
`timescale 1ns/1ps

// miss handling for the fetch cache
// reads one tile per missing line over the memory port and fills the bank

module icMissCtl
(
	input logic clock,
	input logic arstN,
	input logic missEven,
	input logic missOdd,
	input logic [icachePkg::IC_LA_BITS-1:0] reqEven,
	input logic [icachePkg::IC_LA_BITS-1:0] reqOdd,
	input logic [icachePkg::IC_IX_BITS-1:0] ixEven,
	input logic [icachePkg::IC_IX_BITS-1:0] ixOdd,
	input logic [memBusPkg::MEM_TILE_BITS-1:0] memData,
	input memBusPkg::memOkE memOk,
	output memBusPkg::memReqS memReq,
	output icachePkg::bankFillS fillEven,
	output icachePkg::bankFillS fillOdd
);
	import icachePkg::*;
	import memBusPkg::*;

	typedef enum logic [1:0]
	{
		sIdle,
		sPick,	// choose the bank, even first
		sReq,	// rdTile on the port
		sDone	// ready until the port is idle again
	} stateE;

	stateE state;
	logic bankOdd;	// line in flight belongs to the odd bank
	logic [IC_LA_BITS-1:0] lineQ;
	logic [IC_IX_BITS-1:0] ixQ;
	logic memDone;
	logic weEven;
	logic weOdd;
	tagEntryS fillTag;
	logic [IC_IX_BITS-1:0] fillIx;
	logic [IC_LINE_BITS-1:0] fillData;

	// a fault ends the read like ok does
	assign memDone = (memOk == okOk) || (memOk == okFault);

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= sIdle;
			bankOdd <= 1'b0;
			lineQ <= '0;
			ixQ <= '0;
			weEven <= 1'b0;
			weOdd <= 1'b0;
		end
		else
		begin
			weEven <= 1'b0;	// one-cycle strobes
			weOdd <= 1'b0;
			case (state)
				sIdle:
					if (missEven || missOdd)
						state <= sPick;
				sPick:
				begin
					// the pick cycle also lets a fresh bank read settle
					if (missEven)
					begin
						bankOdd <= 1'b0;
						lineQ <= reqEven;
						ixQ <= ixEven;
						state <= sReq;
					end
					else if (missOdd)
					begin
						bankOdd <= 1'b1;
						lineQ <= reqOdd;
						ixQ <= ixOdd;
						state <= sReq;
					end
					else
						state <= sIdle;
				end
				sReq:
					if (memDone)
					begin
						weEven <= !bankOdd;
						weOdd <= bankOdd;
						state <= sDone;
					end
				default:
					if (memOk == okReady)
						state <= sIdle;
			endcase
		end
	end

	// fill payload taken with the tile
	always_ff @(posedge clock)
	begin
		if ((state == sReq) && memDone)
		begin
			fillData <= memData;
			fillIx <= ixQ;
			fillTag.lineAddr <= lineQ;
			fillTag.flag <= {2'b00, ~lineQ[1:0]};
		end
	end

	assign memReq.addr = {lineQ, 4'h0};
	assign memReq.opm = (state == sReq) ? opmRdTile : opmReady;

	always_comb
	begin
		fillEven.we = weEven;
		fillEven.ix = fillIx;
		fillEven.tag = fillTag;
		fillEven.data = fillData;
		fillOdd.we = weOdd;
		fillOdd.ix = fillIx;
		fillOdd.tag = fillTag;
		fillOdd.data = fillData;
	end

endmodule

// ==== list.f ====
common/memBusPkg.sv
common/icachePkg.sv
icache/icBank.sv
icache/icFetchAlign.sv
icache/icMissCtl.sv
hdl/icFetchTop.sv
dv/icFetchTb.sv
